// ==== testbench/decodeStage_stim.txt ====
// hex columns: mode upInstr upRs upRt upNeed upExt dnRs dnRt dnNeed wbNum wbData pbaNum pbaData
// st0..st5 {writeNum,ready} dang flush exeAllowin mask sel allowin upV dnV rd fwd op0 op1
// mask bits 1 allowin, 2 valids, 4 readData, 8 fwdSel, 10 operands; sel = {slot, operand}
// register writes, PBA wins on reg 9
0 0 0 0 0 0 0 0 0 5 1234abcd 7 cafef00d 00 00 00 00 00 00 0 0 1 03 0 1 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 9 11111111 9 22222222 00 00 00 00 00 00 0 0 1 03 0 1 0 0 0 0 0 0
// back to back issue, read data and the four extend modes
3 00a94a80 5 9 3 0 7 0 1 0 0 0 0 00 00 00 00 00 00 0 0 1 03 0 1 0 0 0 0 0 0
3 3c6c8a41 9 0 1 1 0 7 2 0 0 0 0 00 00 00 00 00 00 0 0 1 1f 0 1 1 1 1234abcd 40 0a 00004a80
3 3c6c8a41 0 9 2 2 7 5 3 0 0 0 0 00 00 00 00 00 00 0 0 1 1f 1 1 1 1 0 40 09 ffff8a41
3 00a94a80 5 9 3 3 7 5 3 0 0 0 0 00 00 00 00 00 00 0 0 1 1f 1 1 1 1 22222222 40 09 8a410000
// forwarding priority among ready stages
3 00a94a80 9 5 3 0 7 0 1 0 0 0 0 00 0b 00 0b 00 00 0 0 1 1f 0 1 1 1 1234abcd 02 0a 00a94a80
3 00a94a80 5 9 3 0 7 0 1 0 0 0 0 00 00 0b 00 0b 13 0 0 1 1f 1 1 1 1 1234abcd 04 0a 00004a80
// stall on an unready EXE-down result, then release
3 3c6c8a41 7 0 1 3 0 0 0 0 0 0 0 12 00 13 00 00 00 0 0 1 1f 1 0 0 0 22222222 00 0a 00004a80
3 3c6c8a41 7 0 1 3 0 0 0 0 0 0 0 12 00 13 00 00 00 0 0 1 1f 1 0 0 0 22222222 00 0a 00004a80
3 3c6c8a41 7 0 1 3 0 0 0 0 0 0 0 13 00 13 00 00 00 0 0 1 1f 1 1 1 1 22222222 01 0a 00004a80
// dangerous instruction downstream
0 0 0 0 0 0 0 0 0 0 0 0 0 00 00 00 00 00 00 4 0 1 1f 0 0 0 0 cafef00d 40 09 006c8a41
3 00a94a80 5 9 3 0 7 0 1 0 0 0 0 00 00 00 00 00 00 0 0 1 1f 0 1 1 1 cafef00d 40 09 006c8a41
// flush drops the incoming pair and clears the stage
3 3c6c8a41 9 5 3 1 0 0 0 0 0 0 0 00 00 00 00 00 00 0 1 1 1f 0 1 0 0 1234abcd 40 0a 00004a80
2 3c6c8a41 9 5 3 1 0 0 0 0 0 0 0 00 00 00 00 00 00 0 0 1 1f 0 1 0 0 0 40 0 0
// back-pressure from EXE
0 0 0 0 0 0 0 0 0 0 0 0 0 00 00 00 00 00 00 0 0 0 1f 0 0 0 0 22222222 40 09 ffff8a41
0 0 0 0 0 0 0 0 0 0 0 0 0 00 00 00 00 00 00 0 0 0 1f 0 0 0 0 22222222 40 09 ffff8a41
0 0 0 0 0 0 0 0 0 0 0 0 0 00 00 00 00 00 00 0 0 1 1f 0 1 1 0 22222222 40 09 ffff8a41
0 0 0 0 0 0 0 0 0 0 0 0 0 00 00 00 00 00 00 0 0 0 1f 0 1 0 0 0 40 0 0
// a write shows on the read port one cycle later
3 00a94a80 5 9 3 0 7 0 1 0 0 0 0 00 00 00 00 00 00 0 0 1 03 0 1 0 0 0 0 0 0
3 00a94a80 5 9 3 0 7 0 1 5 5a5a5a5a 0 0 00 00 00 00 00 00 0 0 1 1f 0 1 1 1 1234abcd 40 0a 00004a80
0 0 0 0 0 0 0 0 0 0 0 0 0 00 00 00 00 00 00 0 0 1 1f 0 1 1 1 5a5a5a5a 40 0a 00004a80

// ==== vlog.f ====
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/issueLatch.sv
verilog/regFile.sv
verilog/forwardSelect.sv
verilog/operandGen.sv
verilog/issueControl.sv
verilog/decodeStage.sv
testbench/decodeStage_checker.sv
testbench/decodeStage_tb.sv

// ==== testbench/decodeStage_tb.sv ====
// decode stage testbench
`timescale 1ns/100ps

module decodeStage_tb
    import isaPkg::*;
    import pipePkg::*;
();

    localparam int    NUM_FWD     = 6;
    localparam int    NUM_DANGER  = 4;
    localparam int    FIELDS      = 31;    // columns per vector
    localparam int    MAX_VECTORS = 64;
    localparam string STIM_FILE   = "testbench/decodeStage_stim.txt";

    // column offsets within a vector
    localparam int COL_MODE  = 0;
    localparam int COL_UP    = 1;     // instr rs rt need ext
    localparam int COL_DN    = 6;     // rs rt need
    localparam int COL_WB    = 9;     // wbNum wbData pbaNum pbaData
    localparam int COL_STAGE = 13;
    localparam int COL_CTL   = 19;    // dangerous flush exeAllowin
    localparam int COL_EXP   = 22;    // mask sel allowin up dn rd fwd op0 op1

    logic         clk;
    logic         rstN;
    logic [1:0]   issueMode;
    issueSlot_t   slots [2];
    logic         wbEn;
    regNum_t      wbNum;
    word_t        wbData;
    logic         pbaEn;
    regNum_t      pbaNum;
    word_t        pbaData;
    stageStatus_t fwdStages [NUM_FWD];
    logic [NUM_DANGER-1:0] dangerous;
    logic         flush;
    logic         exeAllowin;
    logic         allowin;
    logic         upValid;
    logic         downValid;
    slotOut_t     slotsOut [2];

    logic [31:0] stim [0:FIELDS*MAX_VECTORS-1];
    logic [31:0] row [FIELDS];
    int          numVectors = 0;
    int          heldVec = -1;   // vector held in the stage register (-1 for empty)

    decodeStage #(
        .NUM_FWD_STAGES  (NUM_FWD),
        .NUM_DANGER_SRCS (NUM_DANGER)
    ) u_decodeStage (
        .clk          (clk),
        .rstN_i       (rstN),
        .issueMode_i  (issueMode),
        .slots_i      (slots),
        .wbEn_i       (wbEn),
        .wbNum_i      (wbNum),
        .wbData_i     (wbData),
        .pbaEn_i      (pbaEn),
        .pbaNum_i     (pbaNum),
        .pbaData_i    (pbaData),
        .fwdStages_i  (fwdStages),
        .dangerous_i  (dangerous),
        .flush_i      (flush),
        .exeAllowin_i (exeAllowin),
        .allowin_o    (allowin),
        .upValid_o    (upValid),
        .downValid_o  (downValid),
        .slotsOut_o   (slotsOut)
    );

    bind decodeStage decodeStage_checker u_checker (
        .clk         (clk),
        .rstN_i      (rstN_i),
        .flush_i     (flush_i),
        .allowin_i   (allowin_o),
        .upValid_i   (upValid_o),
        .downValid_i (downValid_o),
        .latchMode_i (latchMode)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // stimulus helpers

    // per slot address and destination, unique to each vector
    function automatic word_t slotAddr(input int vec, input int s);
        return 32'hbfc0_0000 + 32'(vec * 8 + s * 4);
    endfunction

    function automatic regNum_t slotDest(input int vec, input int s);
        return regNum_t'(vec * 2 + s + 1);
    endfunction

    task automatic idleInputs();
        issueMode = 2'b00;
        slots[0] = '0;
        slots[1] = '0;
        {wbEn, wbNum, wbData} = '0;
        {pbaEn, pbaNum, pbaData} = '0;
        for (int s = 0; s < NUM_FWD; s++) begin
            fwdStages[s] = '0;
        end
        dangerous  = '0;
        flush      = 1'b0;
        exeAllowin = 1'b1;
    endtask

    task automatic fetchRow(input int vec);
        for (int c = 0; c < FIELDS; c++) begin
            row[c] = stim[vec*FIELDS + c];
        end
    endtask

    task automatic applyInputs(input int vec);
        issueMode = row[COL_MODE][1:0];
        for (int s = 0; s < 2; s++) begin
            slots[s]          = '0;
            slots[s].vAddr    = slotAddr(vec, s);
            slots[s].writeNum = slotDest(vec, s);
        end
        slots[0].instr      = row[COL_UP];
        slots[0].readNum[0] = row[COL_UP+1][4:0];
        slots[0].readNum[1] = row[COL_UP+2][4:0];
        slots[0].needRead   = row[COL_UP+3][1:0];
        slots[0].extMode    = extendMode_t'(row[COL_UP+4][1:0]);
        slots[1].readNum[0] = row[COL_DN][4:0];
        slots[1].readNum[1] = row[COL_DN+1][4:0];
        slots[1].needRead   = row[COL_DN+2][1:0];
        wbNum   = row[COL_WB][4:0];
        wbEn    = (wbNum != '0);      // register 0 in the column means idle
        wbData  = row[COL_WB+1];
        pbaNum  = row[COL_WB+2][4:0];
        pbaEn   = (pbaNum != '0);
        pbaData = row[COL_WB+3];
        for (int s = 0; s < NUM_FWD; s++) begin
            fwdStages[s] = row[COL_STAGE+s][5:0];   // {writeNum, fwdReady}
        end
        dangerous  = row[COL_CTL][NUM_DANGER-1:0];
        flush      = row[COL_CTL+1][0];
        exeAllowin = row[COL_CTL+2][0];
    endtask

    // stage register contents after the coming edge
    task automatic trackLatch(input int vec);
        logic expAllowin;
        expAllowin = row[COL_EXP+2][0];
        if (flush || (expAllowin && (issueMode == 2'b00))) begin
            heldVec = -1;
        end else if (expAllowin) begin
            heldVec = vec;
        end
    endtask

    //////////////////////////////
    // response checks

    task automatic expectEqual(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic checkAssertions();
        if (u_decodeStage.u_checker.failCount != 0) begin
            $display("a bound assertion on the decode stage failed");
            $display("Testbench failed");
            $fatal(1, "assertion failure");
        end
    endtask

    task automatic compareOutputs();
        logic [31:0]    mask;
        int             slot;
        int             op;
        logic [NUM_FWD:0] fwd;
        mask = row[COL_EXP];
        slot = int'(row[COL_EXP+1][1]);
        op   = int'(row[COL_EXP+1][0]);
        if (mask[0]) begin
            expectEqual("allowin_o", row[COL_EXP+2], 32'(allowin));
        end
        if (mask[1]) begin
            expectEqual("upValid_o", row[COL_EXP+3], 32'(upValid));
            expectEqual("downValid_o", row[COL_EXP+4], 32'(downValid));
        end
        if (mask[2]) begin
            expectEqual($sformatf("slotsOut_o[%0d].readData[%0d]", slot, op),
                        row[COL_EXP+5], slotsOut[slot].readData[op]);
        end
        if (mask[3]) begin
            fwd = (op == 0) ? slotsOut[slot].fwdSel0 : slotsOut[slot].fwdSel1;
            expectEqual($sformatf("slotsOut_o[%0d].fwdSel%0d", slot, op),
                        row[COL_EXP+6], 32'(fwd));
        end
        if (mask[4]) begin
            expectEqual($sformatf("slotsOut_o[%0d].operand0", slot),
                        row[COL_EXP+7], slotsOut[slot].operand0);
            expectEqual($sformatf("slotsOut_o[%0d].operand1", slot),
                        row[COL_EXP+8], slotsOut[slot].operand1);
        end
        // a cleared stage register carries an all zero payload
        for (int s = 0; s < 2; s++) begin
            expectEqual($sformatf("slotsOut_o[%0d].vAddr", s),
                        (heldVec < 0) ? 32'd0 : slotAddr(heldVec, s),
                        slotsOut[s].vAddr);
            expectEqual($sformatf("slotsOut_o[%0d].writeNum", s),
                        (heldVec < 0) ? 32'd0 : 32'(slotDest(heldVec, s)),
                        32'(slotsOut[s].writeNum));
        end
    endtask

    //////////////////////////////
    // main sequence

    initial begin
        int count;
        idleInputs();
        rstN = 1'b0;
        // unwritten words keep an address tagged pattern, never a valid mode
        for (int i = 0; i < FIELDS*MAX_VECTORS; i++) begin
            stim[i] = {16'hfeed, 16'(i)};
        end
        $readmemh(STIM_FILE, stim);
        count = 0;
        while ((count < MAX_VECTORS) && (stim[count*FIELDS] < 32'd4)) begin
            count++;
        end
        numVectors = count;

        if (count == 0) begin
            $display("no stimulus vectors found in %s", STIM_FILE);
            $display("Testbench failed");
            $fatal(1, "empty stimulus");
        end else if (stim[count*FIELDS-1] == {16'hfeed, 16'(count*FIELDS-1)}) begin
            $display("the last stimulus line has too few columns");
            $display("Testbench failed");
            $fatal(1, "malformed stimulus");
        end else begin
            repeat (5) @(posedge clk);
            #1;
            rstN = 1'b1;
            for (int v = 0; v < count; v++) begin
                fetchRow(v);
                applyInputs(v);
                #8;             // just before the next edge
                checkAssertions();
                compareOutputs();
                trackLatch(v);
                @(posedge clk);
                #1;
            end
            if (u_decodeStage.u_checker.failCount != 0) begin
                $display("a bound assertion on the decode stage failed");
                $display("Testbench failed");
                $fatal(1, "assertion failure");
            end else begin
                $display("Testbench passed");
                $finish;
            end
        end
    end

    // one period per vector plus room for reset
    initial begin
        wait (numVectors > 0);
        #((numVectors + 20) * 10);
        $display("timeout, the vectors did not finish in the expected time");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== testbench/decodeStage_checker.sv ====
// decode stage assertions
`timescale 1ns/100ps

module decodeStage_checker (
    input logic       clk,
    input logic       rstN_i,
    input logic       flush_i,
    input logic       allowin_i,
    input logic       upValid_i,
    input logic       downValid_i,
    input logic [1:0] latchMode_i    // stage register mode
);

    logic anyValid;
    int   failCount = 0;   // assertion failures so far

    assign anyValid = upValid_i || downValid_i;

    //////////////////////////////
    // reset

    a_validLowInReset: assert property (@(posedge clk) !rstN_i |-> !anyValid)
        else begin
            $error("a valid was high while reset was asserted");
            failCount++;
        end

    a_validLowAfterReset: assert property (@(posedge clk) $rose(rstN_i) |-> !anyValid)
        else begin
            $error("a valid was high on the first edge after reset");
            failCount++;
        end

    //////////////////////////////
    // handshake

    a_noValidOnFlush: assert property (@(posedge clk) disable iff (!rstN_i)
        flush_i |-> !anyValid)
        else begin
            $error("a valid was high during a flush");
            failCount++;
        end

    // a full stage that refuses input must not issue either
    a_noValidWhenBlocked: assert property (@(posedge clk) disable iff (!rstN_i)
        (!allowin_i && (latchMode_i != 2'b00)) |-> !anyValid)
        else begin
            $error("a valid was high while the stage was stalled");
            failCount++;
        end

endmodule

// ==== verilog/decodeStage.sv ====
// dual issue decode stage, top level
`timescale 1ns/100ps

module decodeStage
    import isaPkg::*;
    import pipePkg::*;
#(
    parameter int NUM_FWD_STAGES  = MAX_FWD_STAGES,
    parameter int NUM_DANGER_SRCS = 4
) (
    input  logic                       clk,
    input  logic                       rstN_i,

    // from the issue queue
    input  logic [1:0]                 issueMode_i,   // [1] up, [0] down present
    input  issueSlot_t                 slots_i [2],   // [0] up, [1] down

    // register writeback
    input  logic                       wbEn_i,
    input  regNum_t                    wbNum_i,
    input  word_t                      wbData_i,
    input  logic                       pbaEn_i,
    input  regNum_t                    pbaNum_i,
    input  word_t                      pbaData_i,

    // downstream state
    input  stageStatus_t               fwdStages_i [NUM_FWD_STAGES],
    input  logic [NUM_DANGER_SRCS-1:0] dangerous_i,
    input  logic                       flush_i,
    input  logic                       exeAllowin_i,

    // handshake and issued slots
    output logic                       allowin_o,
    output logic                       upValid_o,
    output logic                       downValid_o,
    output slotOut_t                   slotsOut_o [2]
);

    logic [1:0]              latchMode;
    issueSlot_t              latchSlots [2];
    logic                    latchLoad;
    logic                    latchClear;
    regNum_t                 rfReadNum [4];
    word_t                   rfReadData [4];
    logic [1:0]              conflict;
    logic [NUM_FWD_STAGES:0] fwdSel [2][2];   // [slot][operand]
    word_t                   operand0 [2];
    word_t                   operand1 [2];

    //////////////////////////////
    // stage register and control

    issueLatch u_issueLatch (
        .clk     (clk),
        .rstN_i  (rstN_i),
        .mode_i  (issueMode_i),
        .slots_i (slots_i),
        .load_i  (latchLoad),
        .clear_i (latchClear),
        .mode_o  (latchMode),
        .slots_o (latchSlots)
    );

    issueControl #(
        .NUM_FWD_STAGES  (NUM_FWD_STAGES),
        .NUM_DANGER_SRCS (NUM_DANGER_SRCS)
    ) u_issueControl (
        .mode_i       (latchMode),
        .inMode_i     (issueMode_i),
        .conflict_i   (conflict),
        .dangerous_i  (dangerous_i),
        .exeAllowin_i (exeAllowin_i),
        .flush_i      (flush_i),
        .allowin_o    (allowin_o),
        .upValid_o    (upValid_o),
        .downValid_o  (downValid_o),
        .load_o       (latchLoad),
        .clear_o      (latchClear)
    );

    regFile u_regFile (
        .clk        (clk),
        .rstN_i     (rstN_i),
        .readNum_i  (rfReadNum),
        .readData_o (rfReadData),
        .wbEn_i     (wbEn_i),
        .wbNum_i    (wbNum_i),
        .wbData_i   (wbData_i),
        .pbaEn_i    (pbaEn_i),
        .pbaNum_i   (pbaNum_i),
        .pbaData_i  (pbaData_i)
    );

    //////////////////////////////
    // per slot operand path

    for (genvar s = 0; s < 2; s++) begin : g_slot
        assign rfReadNum[2*s]   = latchSlots[s].readNum[0];   // rs
        assign rfReadNum[2*s+1] = latchSlots[s].readNum[1];   // rt

        forwardSelect #(
            .NUM_FWD_STAGES (NUM_FWD_STAGES)
        ) u_forwardSelect (
            .slot_i     (latchSlots[s]),
            .stages_i   (fwdStages_i),
            .fwdSel_o   (fwdSel[s]),
            .conflict_o (conflict[s])
        );

        operandGen u_operandGen (
            .slot_i     (latchSlots[s]),
            .operand0_o (operand0[s]),
            .operand1_o (operand1[s])
        );

        // output packing
        assign slotsOut_o[s].writeNum    = latchSlots[s].writeNum;
        assign slotsOut_o[s].vAddr       = latchSlots[s].vAddr;
        assign slotsOut_o[s].readData[0] = rfReadData[2*s];
        assign slotsOut_o[s].readData[1] = rfReadData[2*s+1];
        assign slotsOut_o[s].operand0    = operand0[s];
        assign slotsOut_o[s].operand1    = operand1[s];
        assign slotsOut_o[s].fwdSel0     = fwdSel[s][0];
        assign slotsOut_o[s].fwdSel1     = fwdSel[s][1];
    end

endmodule

// ==== verilog/issueControl.sv ====
// issue interlock and handshake
`timescale 1ns/100ps

module issueControl #(
    parameter int NUM_FWD_STAGES  = 6,
    parameter int NUM_DANGER_SRCS = 4
) (
    input  logic [1:0]                 mode_i,        // latched mode
    input  logic [1:0]                 inMode_i,      // mode from the issue queue
    input  logic [1:0]                 conflict_i,    // [0] up, [1] down
    input  logic [NUM_DANGER_SRCS-1:0] dangerous_i,
    input  logic                       exeAllowin_i,
    input  logic                       flush_i,
    output logic                       allowin_o,
    output logic                       upValid_o,
    output logic                       downValid_o,
    output logic                       load_o,
    output logic                       clear_o
);

    logic stop;
    logic issueOk;
    logic stageEmpty;
    logic inEmpty;

    //////////////////////////////
    // interlock

    // any unready operand or a dangerous instruction below stalls both slots
    assign stop = (|conflict_i) || (|dangerous_i);

    assign stageEmpty = (mode_i == 2'b00);
    assign inEmpty    = (inMode_i == 2'b00);

    assign allowin_o = stageEmpty || (exeAllowin_i && !stop);

    assign issueOk     = !stop && exeAllowin_i && !flush_i;
    assign upValid_o   = mode_i[1] && issueOk;
    assign downValid_o = mode_i[0] && issueOk;

    //////////////////////////////
    // stage register update

    assign load_o  = allowin_o && !inEmpty;
    assign clear_o = flush_i || (allowin_o && inEmpty);   // flush wins in the latch

endmodule

// ==== verilog/operandGen.sv ====
// shift amount and immediate operands for one slot
`timescale 1ns/100ps

module operandGen
    import isaPkg::*;
    import pipePkg::*;
(
    input  issueSlot_t slot_i,
    output word_t      operand0_o,   // sa
    output word_t      operand1_o    // extended immediate
);

    regView_t rView;
    immView_t iView;

    assign rView = slot_i.instr.regView;
    assign iView = slot_i.instr.immView;

    // shift amount, zero extended
    assign operand0_o = {27'b0, rView.sa};

    //////////////////////////////
    // immediate extension

    always_comb begin
        case (slot_i.extMode)
            EXT_ZERO: begin
                operand1_o = {16'b0, iView.imm16};
            end
            EXT_SIGN: begin
                operand1_o = {{16{iView.imm16[15]}}, iView.imm16};
            end
            EXT_UPPER: begin
                operand1_o = {iView.imm16, 16'b0};   // lui
            end
            EXT_INDEX: begin
                // rs, rt and imm16 together are the 26 bit instr_index
                operand1_o = {6'b0, iView.rs, iView.rt, iView.imm16};
            end
            default: begin
                operand1_o = '0;
            end
        endcase
    end

endmodule

// ==== verilog/forwardSelect.sv ====
// forwarding source select for one slot
`timescale 1ns/100ps

module forwardSelect
    import pipePkg::*;
#(
    parameter int NUM_FWD_STAGES = 6
) (
    input  issueSlot_t              slot_i,
    input  stageStatus_t            stages_i [NUM_FWD_STAGES],  // [0] highest priority
    output logic [NUM_FWD_STAGES:0] fwdSel_o [2],               // [0] rs, [1] rt
    output logic                    conflict_o                  // operand not ready
);

    logic [NUM_FWD_STAGES-1:0] hit [2];    // stage writes this register
    logic [1:0]                opConflict;

    //////////////////////////////
    // match against the stage write numbers

    always_comb begin
        for (int op = 0; op < 2; op++) begin
            for (int s = 0; s < NUM_FWD_STAGES; s++) begin
                hit[op][s] = (slot_i.readNum[op] != '0) &&
                             (stages_i[s].writeNum == slot_i.readNum[op]);
            end
        end
    end

    //////////////////////////////
    // priority pick, gated by ready

    always_comb begin
        for (int op = 0; op < 2; op++) begin
            fwdSel_o[op] = '0;
            fwdSel_o[op][NUM_FWD_STAGES] = 1'b1;   // default, register file

            // walk from lowest priority up so index 0 ends on top
            for (int s = NUM_FWD_STAGES - 1; s >= 0; s--) begin
                if (hit[op][s]) begin
                    fwdSel_o[op] = '0;
                    // a matching stage still computing leaves the select empty
                    fwdSel_o[op][s] = stages_i[s].fwdReady;
                end
            end

            opConflict[op] = slot_i.needRead[op] && (fwdSel_o[op] == '0);
        end
    end

    assign conflict_o = |opConflict;

endmodule

// ==== verilog/regFile.sv ====
// general register file
// 32 x 32, four read ports, two write ports
`timescale 1ns/100ps

module regFile
    import isaPkg::*;
(
    input  logic    clk,
    input  logic    rstN_i,

    // read ports, {down.rt, down.rs, up.rt, up.rs}
    input  regNum_t readNum_i [4],
    output word_t   readData_o [4],

    // write ports
    input  logic    wbEn_i,
    input  regNum_t wbNum_i,
    input  word_t   wbData_i,
    input  logic    pbaEn_i,
    input  regNum_t pbaNum_i,
    input  word_t   pbaData_i
);

    word_t regs [31:1];  // $zero has no storage

    //////////////////////////////
    // write side

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int r = 1; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (wbEn_i && (wbNum_i != '0)) begin
                regs[wbNum_i] <= wbData_i;
            end
            // PBA is the younger result, so it goes last
            if (pbaEn_i && (pbaNum_i != '0)) begin
                regs[pbaNum_i] <= pbaData_i;
            end
        end
    end

    //////////////////////////////
    // read side

    // no write-through, a write is seen from the next cycle
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (readNum_i[p] == '0) begin
                readData_o[p] = '0;
            end else begin
                readData_o[p] = regs[readNum_i[p]];
            end
        end
    end

endmodule

// ==== verilog/issueLatch.sv ====
// issue stage register
`timescale 1ns/100ps

module issueLatch
    import pipePkg::*;
(
    input  logic       clk,
    input  logic       rstN_i,
    input  logic [1:0] mode_i,       // incoming issue mode
    input  issueSlot_t slots_i [2],  // [0] up, [1] down
    input  logic       load_i,
    input  logic       clear_i,
    output logic [1:0] mode_o,
    output issueSlot_t slots_o [2]
);

    //////////////////////////////
    // mode, the control half

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            mode_o <= 2'b00;
        end else if (clear_i) begin  // flush or empty issue
            mode_o <= 2'b00;
        end else if (load_i) begin
            mode_o <= mode_i;
        end
    end

    //////////////////////////////
    // slot payload

    // cleared together with the mode so a bubble carries no stale
    // read numbers into the forwarding logic
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int s = 0; s < 2; s++) begin
                slots_o[s] <= '0;
            end
        end else if (clear_i) begin
            for (int s = 0; s < 2; s++) begin
                slots_o[s] <= '0;
            end
        end else if (load_i) begin
            for (int s = 0; s < 2; s++) begin
                slots_o[s] <= slots_i[s];
            end
        end
        // otherwise hold
    end

endmodule

// ==== verilog/pipePkg.sv ====
// pipeline types
// issue slot, downstream stage status, per-slot stage output
package pipePkg;

    import isaPkg::*;

    // forwarding sources downstream of issue
    // EXE-down, EXE-up, PREMEM, SBA, MEM, REEXE
    localparam int MAX_FWD_STAGES = 6;

    // one-hot, bit i = stage i, top bit = register file
    typedef logic [MAX_FWD_STAGES:0] fwdSel_t;

    //////////////////////////////
    // from the issue queue

    typedef struct packed {
        instr_t        instr;
        word_t         vAddr;
        regNum_t [1:0] readNum;    // [0] rs, [1] rt
        logic [1:0]    needRead;   // operand really consumed
        regNum_t       writeNum;   // 0 = no writeback
        extendMode_t   extMode;
    } issueSlot_t;

    //////////////////////////////
    // from the stages below

    typedef struct packed {
        regNum_t writeNum;
        logic    fwdReady;   // result already computed
    } stageStatus_t;

    //////////////////////////////
    // to EXE

    typedef struct packed {
        regNum_t     writeNum;
        word_t       vAddr;
        word_t [1:0] readData;   // raw rs / rt from the register file
        word_t       operand0;   // sa
        word_t       operand1;   // extended immediate
        fwdSel_t     fwdSel0;
        fwdSel_t     fwdSel1;
    } slotOut_t;

endpackage

// ==== verilog/isaPkg.sv ====
// instruction set types
// word, register number, instruction views, extend modes
package isaPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regNum_t;   // 0 = none or $zero
    typedef logic [5:0]  opcode_t;

    //////////////////////////////
    // instruction word views

    // R-type layout
    typedef struct packed {
        opcode_t    opcode;
        regNum_t    rs;
        regNum_t    rt;
        regNum_t    rd;
        logic [4:0] sa;      // shift amount
        logic [5:0] funct;
    } regView_t;

    // I-type layout, rs/rt/imm16 also form the J-type index
    typedef struct packed {
        opcode_t     opcode;
        regNum_t     rs;
        regNum_t     rt;
        logic [15:0] imm16;
    } immView_t;

    typedef union packed {
        regView_t regView;
        immView_t immView;
    } instr_t;

    //////////////////////////////
    // immediate extension, predecoded upstream
    typedef enum logic [1:0] {
        EXT_ZERO  = 2'd0,   // {16'b0, imm16}
        EXT_SIGN  = 2'd1,   // sign extended imm16
        EXT_UPPER = 2'd2,   // lui style
        EXT_INDEX = 2'd3    // 26 bit jump index
    } extendMode_t;

endpackage
